//--- files.f
verilog/llc_pkg.sv
verilog/llc_skid_buffer.sv
verilog/llc_req_stage.sv
verilog/llc_interfaces.sv
verif/tb_clk_gen.sv
verif/tb_llc_interfaces.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
TOP        ?= tb_llc_interfaces
RTL_TOP    ?= llc_interfaces
FILELIST   ?= files.f
RTL_FILES  ?= verilog/llc_pkg.sv verilog/llc_skid_buffer.sv \
              verilog/llc_req_stage.sv verilog/llc_interfaces.sv
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_llc_interfaces.sv
`timescale 1ns/100ps

module tb_llc_interfaces;

    localparam int WAIT_LIMIT   = 50;
    localparam int STREAM_LIMIT = 400;
    localparam int NUM_RSP      = 20;

    logic                clk;
    logic                rst;
    logic                req_valid;
    logic                req_ready;
    llc_pkg::llc_req_t   req_data;
    logic                req_pending;
    logic                req_take;
    logic                set_conflict;
    logic                replay;
    llc_pkg::llc_req_t   req_reg;
    llc_pkg::line_addr_t req_addr;
    logic                ctl_rsp_valid;
    logic                ctl_rsp_ready;
    llc_pkg::llc_rsp_t   ctl_rsp;
    logic                net_rsp_valid;
    logic                net_rsp_ready;
    llc_pkg::llc_rsp_t   net_rsp;

    int                  mismatch_count;
    int                  timeout_count;

    tb_clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    llc_interfaces u_llc_interfaces (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid),
        .req_ready_o    (req_ready),
        .req_i          (req_data),
        .req_pending_o  (req_pending),
        .req_take_i     (req_take),
        .set_conflict_i (set_conflict),
        .replay_i       (replay),
        .req_o          (req_reg),
        .req_addr_o     (req_addr),
        .rsp_valid_i    (ctl_rsp_valid),
        .rsp_ready_o    (ctl_rsp_ready),
        .rsp_i          (ctl_rsp),
        .rsp_valid_o    (net_rsp_valid),
        .rsp_ready_i    (net_rsp_ready),
        .rsp_o          (net_rsp)
    );

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_timeout(input string msg);
        timeout_count++;
        $display("timeout at %0t: %s", $time, msg);
    endtask

    function automatic llc_pkg::llc_req_t random_req();
        llc_pkg::llc_req_t r;
        r.coh_msg     = llc_pkg::coh_msg_t'($urandom);
        r.hprot       = 1'($urandom);
        r.addr        = llc_pkg::line_addr_t'($urandom);
        r.line        = {$urandom, $urandom, $urandom, $urandom};
        r.req_id      = llc_pkg::req_id_t'($urandom);
        r.word_offset = 2'($urandom);
        r.valid_words = 2'($urandom);
        r.word_mask   = llc_pkg::word_mask_t'($urandom);
        return r;
    endfunction

    function automatic llc_pkg::llc_rsp_t random_rsp();
        llc_pkg::llc_rsp_t r;
        r.coh_msg     = llc_pkg::coh_msg_t'($urandom);
        r.addr        = llc_pkg::line_addr_t'($urandom);
        r.line        = {$urandom, $urandom, $urandom, $urandom};
        r.invack_cnt  = 4'($urandom);
        r.req_id      = llc_pkg::req_id_t'($urandom);
        r.dest_id     = llc_pkg::req_id_t'($urandom);
        r.word_offset = 2'($urandom);
        r.word_mask   = llc_pkg::word_mask_t'($urandom);
        return r;
    endfunction

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (!rst && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rst) begin
            report_timeout("reset was never released");
        end
        @(negedge clk);
    endtask

    // Offer one request and return on the falling edge after the transfer
    task automatic push_req(input llc_pkg::llc_req_t item, output bit ok);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req_data  = item;
        while (!req_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            report_timeout("req_ready_o never rose to accept a request");
            req_valid = 1'b0;
            ok        = 1'b0;
        end else begin
            @(negedge clk);
            req_valid = 1'b0;
            ok        = 1'b1;
        end
    endtask

    task automatic check_reset_state();
        if (!req_ready) report_mismatch("req_ready_o low after reset");
        if (!ctl_rsp_ready) report_mismatch("rsp_ready_o low after reset");
        if (req_pending) report_mismatch("req_pending_o high after reset");
        if (net_rsp_valid) report_mismatch("rsp_valid_o high after reset");
        if (req_reg !== '0) report_mismatch("req_o not zero after reset");
    endtask

    task automatic pass_through_request();
        llc_pkg::llc_req_t a;
        bit                ok;
        a         = random_req();
        req_take  = 1'b1;
        req_valid = 1'b1;
        req_data  = a;
        #1;
        if (!req_pending) report_mismatch("req_pending_o low while request presented");
        if (req_addr !== a.addr) report_mismatch("req_addr_o differs from presented address");
        push_req(a, ok);
        if (!ok) return;
        if (req_reg !== a) report_mismatch("req_o differs from passed request");
    endtask

    task automatic stall_request_path();
        llc_pkg::llc_req_t a;
        llc_pkg::llc_req_t b;
        llc_pkg::llc_req_t prev;
        bit                ok;
        a        = random_req();
        b        = random_req();
        req_take = 1'b0;
        prev     = req_reg;
        push_req(a, ok);
        if (!ok) return;
        // B waits while A sits in the hold register
        req_valid = 1'b1;
        req_data  = b;
        repeat (3) begin
            #1;
            if (req_ready) report_mismatch("req_ready_o high while A is held");
            if (!req_pending) report_mismatch("req_pending_o low while A is held");
            if (req_addr !== a.addr) report_mismatch("req_addr_o differs from held A");
            if (req_reg !== prev) report_mismatch("req_o changed while req_take_i low");
            @(negedge clk);
        end
        req_take = 1'b1;
        @(negedge clk);
        if (req_reg !== a) report_mismatch("req_o differs from A after release");
        push_req(b, ok);
        if (!ok) return;
        if (req_reg !== b) report_mismatch("req_o differs from B after A");
    endtask

    task automatic replay_conflict();
        llc_pkg::llc_req_t a;
        llc_pkg::llc_req_t b;
        llc_pkg::llc_req_t c;
        bit                ok;
        a        = random_req();
        b        = random_req();
        c        = random_req();
        req_take = 1'b1;
        push_req(a, ok);
        if (!ok) return;
        if (req_reg !== a) report_mismatch("req_o differs from A before conflict");
        set_conflict = 1'b1;
        @(negedge clk);
        set_conflict = 1'b0;
        push_req(b, ok);
        if (!ok) return;
        if (req_reg !== b) report_mismatch("req_o differs from B after conflict");
        replay    = 1'b1;
        // New request in the replay cycle loses to the parked one
        req_valid = 1'b1;
        req_data  = c;
        #1;
        if (req_addr !== a.addr) report_mismatch("req_addr_o differs from parked A");
        @(negedge clk);
        replay    = 1'b0;
        req_valid = 1'b0;
        if (req_reg !== a) report_mismatch("req_o differs from A after replay");
    endtask

    task automatic stream_responses();
        llc_pkg::llc_rsp_t sent_q[$];
        llc_pkg::llc_rsp_t got_q[$];
        for (int i = 0; i < NUM_RSP; i++) begin
            sent_q.push_back(random_rsp());
        end
        fork
            begin
                int waited;
                for (int i = 0; i < NUM_RSP; i++) begin
                    waited        = 0;
                    ctl_rsp_valid = 1'b1;
                    ctl_rsp       = sent_q[i];
                    while (!ctl_rsp_ready && waited < WAIT_LIMIT) begin
                        @(negedge clk);
                        waited++;
                    end
                    if (!ctl_rsp_ready) begin
                        report_timeout("rsp_ready_o never rose to accept a response");
                        break;
                    end
                    @(negedge clk);
                end
                ctl_rsp_valid = 1'b0;
            end
            begin
                int cycles;
                cycles = 0;
                // Sample mid cycle before the transfer edge
                while (got_q.size() < NUM_RSP && cycles < STREAM_LIMIT) begin
                    net_rsp_ready = ($urandom % 2) == 1;
                    #1;
                    if (net_rsp_valid && net_rsp_ready) got_q.push_back(net_rsp);
                    @(negedge clk);
                    cycles++;
                end
            end
        join
        net_rsp_ready = 1'b1;
        if (got_q.size() != NUM_RSP) begin
            report_timeout("not all responses arrived on rsp_o");
        end
        for (int i = 0; i < got_q.size() && i < NUM_RSP; i++) begin
            if (got_q[i] !== sent_q[i]) report_mismatch("response out of order or corrupted");
        end
    endtask

    initial begin
        void'($urandom(33));
        mismatch_count = 0;
        timeout_count  = 0;
        req_valid      = 1'b0;
        req_data       = '0;
        req_take       = 1'b0;
        set_conflict   = 1'b0;
        replay         = 1'b0;
        ctl_rsp_valid  = 1'b0;
        ctl_rsp        = '0;
        net_rsp_ready  = 1'b0;

        wait_reset_release();
        check_reset_state();
        pass_through_request();
        stall_request_path();
        replay_conflict();
        stream_responses();
        repeat (2) @(negedge clk);

        $display("Error counts: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset released on a falling edge, away from the capture edge
    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b1;
    end

endmodule

//--- verilog/llc_interfaces.sv
`timescale 1ns/100ps

module llc_interfaces (
    input  logic                clk,
    input  logic                rst,

    // Coherence request in
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  llc_pkg::llc_req_t   req_i,

    // Handshake with the cache controller
    output logic                req_pending_o,
    input  logic                req_take_i,
    input  logic                set_conflict_i,
    input  logic                replay_i,
    output llc_pkg::llc_req_t   req_o,
    output llc_pkg::line_addr_t req_addr_o,

    // Response from the controller
    input  logic                rsp_valid_i,
    output logic                rsp_ready_o,
    input  llc_pkg::llc_rsp_t   rsp_i,

    // Response toward the network
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output llc_pkg::llc_rsp_t   rsp_o
);

    logic              req_valid_int;
    llc_pkg::llc_req_t req_data_int;

    // Request path
    llc_skid_buffer #(
        .payload_t (llc_pkg::llc_req_t)
    ) u_req_skid (
        .clk     (clk),
        .rst     (rst),
        .valid_i (req_valid_i),
        .ready_o (req_ready_o),
        .data_i  (req_i),
        .valid_o (req_valid_int),
        .ready_i (req_take_i),
        .data_o  (req_data_int)
    );

    // Controller sees the request as soon as it is presented
    assign req_pending_o = req_valid_int;

    llc_req_stage u_req_stage (
        .clk            (clk),
        .rst            (rst),
        .valid_i        (req_valid_int),
        .ready_i        (req_take_i),
        .data_i         (req_data_int),
        .set_conflict_i (set_conflict_i),
        .replay_i       (replay_i),
        .req_o          (req_o),
        .req_addr_o     (req_addr_o)
    );

    // Response path
    llc_skid_buffer #(
        .payload_t (llc_pkg::llc_rsp_t)
    ) u_rsp_skid (
        .clk     (clk),
        .rst     (rst),
        .valid_i (rsp_valid_i),
        .ready_o (rsp_ready_o),
        .data_i  (rsp_i),
        .valid_o (rsp_valid_o),
        .ready_i (rsp_ready_i),
        .data_o  (rsp_o)
    );

endmodule

//--- verilog/llc_req_stage.sv
`timescale 1ns/100ps

module llc_req_stage (
    input  logic                clk,
    input  logic                rst,

    // Request presented by the skid buffer
    input  logic                valid_i,
    input  logic                ready_i,
    input  llc_pkg::llc_req_t   data_i,

    // Controller commands, one-cycle pulses
    input  logic                set_conflict_i,
    input  logic                replay_i,

    // Registered request and lookup address
    output llc_pkg::llc_req_t   req_o,
    output llc_pkg::line_addr_t req_addr_o
);

    llc_pkg::llc_req_t req_q;
    llc_pkg::llc_req_t conflict_q;
    logic              capture;

    // A new request is taken on a valid/ready transfer
    assign capture = valid_i && ready_i;

    // Working copy of the request
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_q <= '0;
        end else if (replay_i) begin
            // Restore the parked request
            req_q <= conflict_q;
        end else if (capture) begin
            req_q <= data_i;
        end
    end

    // Request parked on an address conflict
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            conflict_q <= '0;
        end else if (set_conflict_i) begin
            conflict_q <= req_q;
        end
    end

    assign req_o = req_q;

    // Set lookup happens before the request is registered
    always_comb begin
        if (replay_i) begin
            req_addr_o = conflict_q.addr;
        end else begin
            req_addr_o = data_i.addr;
        end
    end

endmodule

//--- verilog/llc_skid_buffer.sv
`timescale 1ns/100ps

module llc_skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,

    // Upstream side
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,

    // Downstream side
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     held_q;
    payload_t hold_q;
    logic     accept;
    logic     park;

    // Upstream ready comes straight from the flag register
    assign ready_o = !held_q;
    assign accept  = valid_i && ready_o;

    // Accepted while downstream stalls, so keep a copy
    assign park = accept && !ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            held_q <= 1'b0;
        end else if (park) begin
            held_q <= 1'b1;
        end else if (held_q && ready_i) begin
            held_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (park) begin
            hold_q <= data_i;
        end
    end

    // Held item has priority, otherwise pass through
    always_comb begin
        if (held_q) begin
            valid_o = 1'b1;
            data_o  = hold_q;
        end else begin
            valid_o = valid_i;
            data_o  = data_i;
        end
    end

endmodule

//--- verilog/llc_pkg.sv
package llc_pkg;

    // Line and word geometry
    localparam int ADDR_BITS      = 28;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_BITS      = 32;
    localparam int LINE_BITS      = WORDS_PER_LINE * WORD_BITS;
    localparam int WORD_OFF_BITS  = $clog2(WORDS_PER_LINE);

    // Message field widths
    localparam int COH_MSG_BITS   = 5;
    localparam int REQ_ID_BITS    = 4;
    localparam int INVACK_BITS    = 4;

    typedef logic [ADDR_BITS-1:0]      line_addr_t;
    typedef logic [LINE_BITS-1:0]      line_t;
    typedef logic [WORDS_PER_LINE-1:0] word_mask_t;
    typedef logic [COH_MSG_BITS-1:0]   coh_msg_t;
    typedef logic [REQ_ID_BITS-1:0]    req_id_t;

    // Coherence request from a private cache
    typedef struct packed {
        coh_msg_t                 coh_msg;
        logic                     hprot;
        line_addr_t               addr;
        line_t                    line;
        req_id_t                  req_id;
        logic [WORD_OFF_BITS-1:0] word_offset;
        logic [WORD_OFF_BITS-1:0] valid_words;
        word_mask_t               word_mask;
    } llc_req_t;

    // Response sent back toward the requester
    typedef struct packed {
        coh_msg_t                 coh_msg;
        line_addr_t               addr;
        line_t                    line;
        logic [INVACK_BITS-1:0]   invack_cnt;
        req_id_t                  req_id;
        req_id_t                  dest_id;
        logic [WORD_OFF_BITS-1:0] word_offset;
        word_mask_t               word_mask;
    } llc_rsp_t;

endpackage
